// ==== rtl/snake_consts.svh ====
`ifndef SNAKE_CONSTS_SVH
`define SNAKE_CONSTS_SVH

// Playing field in cells
`define SNAKE_FIELD_W 32
`define SNAKE_FIELD_H 32
`define SNAKE_CELL_PX 8
`define SNAKE_FIELD_X0 80
`define SNAKE_FIELD_Y0 80
`define SNAKE_MAX_LEN 16

// 640x480 screen, counted in pixel clocks
`define SNAKE_H_VISIBLE 640
`define SNAKE_H_TOTAL 800
`define SNAKE_HSYNC_START 656
`define SNAKE_HSYNC_LEN 96
`define SNAKE_V_VISIBLE 480
`define SNAKE_V_TOTAL 525
`define SNAKE_VSYNC_START 490
`define SNAKE_VSYNC_LEN 2

// RGB332 colours
`define SNAKE_COLOR_BODY 8'b111_111_11
`define SNAKE_COLOR_COIN 8'b111_111_00
`define SNAKE_COLOR_BG 8'b100_100_10

// Start cell of the head, first coin
`define SNAKE_START_X 16
`define SNAKE_START_Y 16
`define SNAKE_COIN0_X 20
`define SNAKE_COIN0_Y 16
`define SNAKE_TICK_DIV 25_000_000

`endif

// ==== rtl/snake_pkg.sv ====
`include "snake_consts.svh"

package snake_pkg;

	// Bits per cell coordinate
	localparam int CELL_W = $clog2(`SNAKE_FIELD_W);

	// Opposite directions differ only in bit 1
	typedef enum logic [1:0]
	{
		DIR_RIGHT = 2'd0,
		DIR_UP    = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_DOWN  = 2'd3
	} dir_t;

	// Column and row of one field cell
	typedef struct packed
	{
		logic [CELL_W-1:0] x;
		logic [CELL_W-1:0] y;
	} cell_t;

endpackage

// ==== rtl/game_tick.sv ====
`timescale 1ns/10ps
`include "snake_consts.svh"

module game_tick
#(
	parameter int TICK_DIV = `SNAKE_TICK_DIV
)
(
	input  logic mclk,
	input  logic reset,
	output logic tick
);

	// One spare bit so a ratio of 1 still fits
	localparam int CNT_W = $clog2(TICK_DIV + 1);

	logic [CNT_W-1:0] cnt;

	// Down counter, reload on reaching zero
	// Registered strobe lands TICK_DIV edges after reset
	always_ff @(posedge mclk)
	begin
		if (reset)
		begin
			cnt  <= CNT_W'(TICK_DIV - 1);
			tick <= 1'b0;
		end
		else
		begin
			tick <= (cnt == '0);
			if (cnt == '0)
				cnt <= CNT_W'(TICK_DIV - 1);
			else
				cnt <= cnt - 1'b1;
		end
	end

endmodule

// ==== rtl/direction_ctrl.sv ====
`timescale 1ns/10ps

module direction_ctrl
(
	input  logic             mclk,
	input  logic             reset,
	input  logic [3:0]       btn,
	output snake_pkg::dir_t  dir
);

	import snake_pkg::*;

	dir_t req;
	logic req_valid;

	// Priority decode, highest button index wins
	always_comb
	begin
		req_valid = |btn;
		if (btn[3])
			req = DIR_DOWN;
		else if (btn[2])
			req = DIR_UP;
		else if (btn[1])
			req = DIR_LEFT;
		else
			req = DIR_RIGHT;
	end

	// Reversal means bit 1 flipped, bit 0 equal
	always_ff @(posedge mclk)
	begin
		if (reset)
			dir <= DIR_RIGHT;
		else if (req_valid && (req != dir_t'(dir ^ 2'b10)))
			dir <= req;
	end

endmodule

// ==== rtl/vga_timing.sv ====
`timescale 1ns/10ps
`include "snake_consts.svh"

module vga_timing
(
	input  logic       mclk,
	input  logic       reset,
	output logic       px_en,
	output logic [9:0] px_x,
	output logic [9:0] px_y,
	output logic       px_visible,
	output logic       hsync,
	output logic       vsync
);

	localparam logic [9:0] H_LAST = 10'(`SNAKE_H_TOTAL - 1);
	localparam logic [9:0] V_LAST = 10'(`SNAKE_V_TOTAL - 1);
	localparam logic [9:0] HS_BEG = 10'(`SNAKE_HSYNC_START);
	localparam logic [9:0] HS_END = 10'(`SNAKE_HSYNC_START + `SNAKE_HSYNC_LEN);
	localparam logic [9:0] VS_BEG = 10'(`SNAKE_VSYNC_START);
	localparam logic [9:0] VS_END = 10'(`SNAKE_VSYNC_START + `SNAKE_VSYNC_LEN);

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;

	////////////////////////////////////////////////////////////
	// Pixel strobe and raster counters
	////////////////////////////////////////////////////////////

	// Half rate pixel strobe, no second clock domain
	always_ff @(posedge mclk)
	begin
		if (reset)
			px_en <= 1'b0;
		else
			px_en <= ~px_en;
	end

	always_ff @(posedge mclk)
	begin
		if (reset)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else if (px_en)
		begin
			if (h_cnt == H_LAST)
			begin
				h_cnt <= '0;
				// End of line steps the row
				if (v_cnt == V_LAST)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end
			else
				h_cnt <= h_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Decode, combinational from the counters
	////////////////////////////////////////////////////////////

	assign px_x = h_cnt;
	assign px_y = v_cnt;
	assign px_visible = (h_cnt < 10'(`SNAKE_H_VISIBLE)) && (v_cnt < 10'(`SNAKE_V_VISIBLE));

	// Active low pulses
	assign hsync = ~((h_cnt >= HS_BEG) && (h_cnt < HS_END));
	assign vsync = ~((v_cnt >= VS_BEG) && (v_cnt < VS_END));

endmodule

// ==== rtl/snake_game.sv ====
`timescale 1ns/10ps
`include "snake_consts.svh"

module snake_game
(
	input  logic            mclk,
	input  logic            reset,
	input  logic            tick,
	input  snake_pkg::dir_t dir,
	input  logic [9:0]      px_x,
	input  logic [9:0]      px_y,
	input  logic            px_visible,
	output logic [7:0]      pixel_color,
	output logic            game_over,
	output logic [7:0]      score
);

	import snake_pkg::*;

	localparam int LEN_W = $clog2(`SNAKE_MAX_LEN + 1);
	localparam int CELL_SHIFT = $clog2(`SNAKE_CELL_PX);
	localparam logic [CELL_W-1:0] X_MAX = CELL_W'(`SNAKE_FIELD_W - 1);
	localparam logic [CELL_W-1:0] Y_MAX = CELL_W'(`SNAKE_FIELD_H - 1);
	localparam logic [9:0] FX0 = 10'(`SNAKE_FIELD_X0);
	localparam logic [9:0] FY0 = 10'(`SNAKE_FIELD_Y0);
	localparam logic [9:0] FX1 = 10'(`SNAKE_FIELD_X0 + `SNAKE_FIELD_W * `SNAKE_CELL_PX);
	localparam logic [9:0] FY1 = 10'(`SNAKE_FIELD_Y0 + `SNAKE_FIELD_H * `SNAKE_CELL_PX);
	localparam logic [9:0] LFSR_SEED = 10'h1a5;

	// body[0] is the head
	cell_t body [`SNAKE_MAX_LEN];
	logic [LEN_W-1:0] len;
	cell_t coin;
	logic [9:0] lfsr;

	cell_t next_head;
	logic hit_wall;
	logic hit_body;
	logic move;
	logic eat;

	////////////////////////////////////////////////////////////
	// Next head and collision
	////////////////////////////////////////////////////////////

	always_comb
	begin
		next_head = body[0];
		hit_wall  = 1'b0;
		// Up is towards row 0
		case (dir)
			DIR_RIGHT:
			begin
				hit_wall = (body[0].x == X_MAX);
				next_head.x = body[0].x + 1'b1;
			end
			DIR_UP:
			begin
				hit_wall = (body[0].y == '0);
				next_head.y = body[0].y - 1'b1;
			end
			DIR_LEFT:
			begin
				hit_wall = (body[0].x == '0);
				next_head.x = body[0].x - 1'b1;
			end
			default:
			begin
				hit_wall = (body[0].y == Y_MAX);
				next_head.y = body[0].y + 1'b1;
			end
		endcase
	end

	// Any used segment blocks the head
	always_comb
	begin
		hit_body = 1'b0;
		for (int i = 0; i < `SNAKE_MAX_LEN; i++)
			if ((LEN_W'(i) < len) && (body[i] == next_head))
				hit_body = 1'b1;
	end

	assign move = tick && !game_over && !hit_wall && !hit_body;
	assign eat  = move && (next_head == coin);

	////////////////////////////////////////////////////////////
	// Game state
	////////////////////////////////////////////////////////////

	always_ff @(posedge mclk)
	begin
		if (reset)
		begin
			body[0]   <= '{x: CELL_W'(`SNAKE_START_X), y: CELL_W'(`SNAKE_START_Y)};
			len       <= LEN_W'(1);
			coin      <= '{x: CELL_W'(`SNAKE_COIN0_X), y: CELL_W'(`SNAKE_COIN0_Y)};
			score     <= '0;
			game_over <= 1'b0;
		end
		else
		begin
			if (tick && !game_over && (hit_wall || hit_body))
				game_over <= 1'b1;
			// Head steps ahead and the tail shifts behind it
			if (move)
			begin
				body[0] <= next_head;
				for (int i = 1; i < `SNAKE_MAX_LEN; i++)
					body[i] <= body[i-1];
			end
			if (eat)
			begin
				score <= score + 1'b1;
				if (len < LEN_W'(`SNAKE_MAX_LEN))
					len <= len + 1'b1;
				// New coin from the LFSR value before this step
				coin <= '{x: lfsr[4:0], y: lfsr[9:5]};
			end
		end
	end

	// Galois LFSR for x^10 + x^7 + 1 stepping on every tick
	always_ff @(posedge mclk)
	begin
		if (reset)
			lfsr <= LFSR_SEED;
		else if (tick)
			lfsr <= {1'b0, lfsr[9:1]} ^ (lfsr[0] ? 10'h240 : 10'h000);
	end

	////////////////////////////////////////////////////////////
	// Pixel colour lookup
	////////////////////////////////////////////////////////////

	logic [9:0] rel_x;
	logic [9:0] rel_y;
	logic in_field;
	cell_t px_cell;
	logic px_body;

	assign rel_x = px_x - FX0;
	assign rel_y = px_y - FY0;
	assign in_field = (px_x >= FX0) && (px_x < FX1) && (px_y >= FY0) && (px_y < FY1);
	assign px_cell = '{x: rel_x[CELL_SHIFT +: CELL_W], y: rel_y[CELL_SHIFT +: CELL_W]};

	always_comb
	begin
		px_body = 1'b0;
		for (int i = 0; i < `SNAKE_MAX_LEN; i++)
			if ((LEN_W'(i) < len) && (body[i] == px_cell))
				px_body = 1'b1;
	end

	// Body drawn over coin and black outside the field
	always_ff @(posedge mclk)
	begin
		if (!px_visible || !in_field)
			pixel_color <= 8'h00;
		else if (px_body)
			pixel_color <= `SNAKE_COLOR_BODY;
		else if (px_cell == coin)
			pixel_color <= `SNAKE_COLOR_COIN;
		else
			pixel_color <= `SNAKE_COLOR_BG;
	end

endmodule

// ==== rtl/snake_top.sv ====
`timescale 1ns/10ps
`include "snake_consts.svh"

module snake_top
#(
	parameter int TICK_DIV = `SNAKE_TICK_DIV
)
(
	input  logic       mclk,
	input  logic       reset,
	input  logic [3:0] btn,
	output logic       hsync,
	output logic       vsync,
	output logic [2:0] red,
	output logic [2:0] green,
	output logic [1:0] blue,
	output logic       game_over,
	output logic [7:0] score
);

	import snake_pkg::*;

	logic tick;
	dir_t dir;
	logic [9:0] px_x;
	logic [9:0] px_y;
	logic px_visible;
	logic hsync_raw;
	logic vsync_raw;
	logic [7:0] pixel_color;
	logic [1:0] hsync_dly;
	logic [1:0] vsync_dly;
	logic [7:0] color_q;

	game_tick #(.TICK_DIV(TICK_DIV)) u_tick
	(
		.mclk  (mclk),
		.reset (reset),
		.tick  (tick)
	);

	direction_ctrl u_dir
	(
		.mclk  (mclk),
		.reset (reset),
		.btn   (btn),
		.dir   (dir)
	);

	// Pixel strobe stays inside the timing block
	vga_timing u_vga
	(
		.mclk       (mclk),
		.reset      (reset),
		.px_en      (),
		.px_x       (px_x),
		.px_y       (px_y),
		.px_visible (px_visible),
		.hsync      (hsync_raw),
		.vsync      (vsync_raw)
	);

	snake_game u_game
	(
		.mclk        (mclk),
		.reset       (reset),
		.tick        (tick),
		.dir         (dir),
		.px_x        (px_x),
		.px_y        (px_y),
		.px_visible  (px_visible),
		.pixel_color (pixel_color),
		.game_over   (game_over),
		.score       (score)
	);

	////////////////////////////////////////////////////////////
	// Output alignment
	////////////////////////////////////////////////////////////

	// Colour is one stage late in the game, one more here
	// Syncs get two stages to match
	always_ff @(posedge mclk)
	begin
		if (reset)
		begin
			hsync_dly <= 2'b11;
			vsync_dly <= 2'b11;
			color_q   <= 8'h00;
		end
		else
		begin
			hsync_dly <= {hsync_dly[0], hsync_raw};
			vsync_dly <= {vsync_dly[0], vsync_raw};
			color_q   <= pixel_color;
		end
	end

	assign hsync = hsync_dly[1];
	assign vsync = vsync_dly[1];

	// RGB332 split
	assign red   = color_q[7:5];
	assign green = color_q[4:2];
	assign blue  = color_q[1:0];

endmodule

// ==== testbench/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen
#(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 10
)
(
	output logic mclk,
	output logic reset
);

	int cnt;

	initial
	begin
		mclk  = 1'b0;
		reset = 1'b1;
		cnt   = 0;
	end

	always #(PERIOD_NS / 2) mclk = ~mclk;

	// Release on a falling edge, after RESET_CYCLES rising edges
	always @(negedge mclk)
	begin
		if (cnt < RESET_CYCLES)
		begin
			cnt = cnt + 1;
			if (cnt == RESET_CYCLES)
				reset <= 1'b0;
		end
	end

endmodule

// ==== testbench/tb_snake_top.sv ====
`timescale 1ns/10ps
`include "snake_consts.svh"

module tb_snake_top;

	localparam int TICK = 64;
	localparam int LINE_CYC = 2 * `SNAKE_H_TOTAL;
	localparam int FRAME_CYC = LINE_CYC * `SNAKE_V_TOTAL;
	localparam int RUN_LIMIT = 30 * TICK + 2 * FRAME_CYC;
	// Coin LFSR start value inside the game core
	localparam logic [9:0] COIN_SEED = 10'h1a5;

	logic mclk;
	logic por;
	logic run_rst = 1'b0;
	logic reset;
	logic [3:0] btn = 4'b0000;
	logic hsync;
	logic vsync;
	logic [2:0] red;
	logic [2:0] green;
	logic [1:0] blue;
	logic game_over;
	logic [7:0] score;

	// Reference model of the game
	int run_cyc = 0;
	int m_ticks;
	// Direction as 0 right, 1 up, 2 left, 3 down
	int m_dir;
	int m_len;
	int m_score;
	logic m_over;
	int m_x[`SNAKE_MAX_LEN];
	int m_y[`SNAKE_MAX_LEN];
	int m_cx;
	int m_cy;
	logic [9:0] m_lfsr;

	// Sync edge tracking and reach counters
	int last_hfall;
	int last_vfall;
	logic prev_hs;
	logic prev_vs;
	int vs_periods = 0;
	int body_px = 0;
	int coin_px = 0;
	int bg_px = 0;
	logic [15:0] rng = 16'd69;

	assign reset = por | run_rst;

	clk_gen u_clk
	(
		.mclk  (mclk),
		.reset (por)
	);

	snake_top #(.TICK_DIV(TICK)) DUT
	(
		.mclk      (mclk),
		.reset     (reset),
		.btn       (btn),
		.hsync     (hsync),
		.vsync     (vsync),
		.red       (red),
		.green     (green),
		.blue      (blue),
		.game_over (game_over),
		.score     (score)
	);

	////////////////////////////////////////////////////////////
	// Failure reporting and random bits
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic report_mismatch(input string sig, input longint got, input longint exp);
		abort_run($sformatf("FAIL at %0t: %s is %0h, expected %0h", $time, sig, got, exp));
	endtask

	// Galois LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr16_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | rng[0];
			rng = lfsr16_step(rng);
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Highest button wins and a reversing request is dropped
	function automatic int steer(input int cur, input logic [3:0] b);
		int req;
		if (b == 4'b0000)
			return cur;
		req = b[3] ? 3 : (b[2] ? 1 : (b[1] ? 2 : 0));
		return (req == (cur ^ 2)) ? cur : req;
	endfunction

	task automatic init_model();
		m_ticks = 0;
		m_dir = 0;
		m_len = 1;
		m_score = 0;
		m_over = 1'b0;
		m_x[0] = `SNAKE_START_X;
		m_y[0] = `SNAKE_START_Y;
		m_cx = `SNAKE_COIN0_X;
		m_cy = `SNAKE_COIN0_Y;
		m_lfsr = COIN_SEED;
	endtask

	task automatic step_model();
		int nx;
		int ny;
		logic blocked;
		nx = m_x[0];
		ny = m_y[0];
		case (m_dir)
			0: nx = nx + 1;
			1: ny = ny - 1;
			2: nx = nx - 1;
			default: ny = ny + 1;
		endcase
		blocked = (nx < 0) || (ny < 0) || (nx >= `SNAKE_FIELD_W) || (ny >= `SNAKE_FIELD_H);
		for (int i = 0; i < m_len; i++)
			if ((m_x[i] == nx) && (m_y[i] == ny))
				blocked = 1'b1;
		if (!m_over && blocked)
			m_over = 1'b1;
		else if (!m_over)
		begin
			for (int i = `SNAKE_MAX_LEN - 1; i > 0; i--)
			begin
				m_x[i] = m_x[i-1];
				m_y[i] = m_y[i-1];
			end
			m_x[0] = nx;
			m_y[0] = ny;
			// Coin eaten so the next cell comes from the LFSR before this step
			if ((nx == m_cx) && (ny == m_cy))
			begin
				m_score = m_score + 1;
				if (m_len < `SNAKE_MAX_LEN)
					m_len = m_len + 1;
				m_cx = m_lfsr[4:0];
				m_cy = m_lfsr[9:5];
			end
		end
		// x^10 + x^7 + 1 with the output bit fed back into bits 9 and 6
		m_lfsr = {m_lfsr[0], m_lfsr[9:8], m_lfsr[7] ^ m_lfsr[0], m_lfsr[6:1]};
		m_ticks = m_ticks + 1;
	endtask

	// Colour of one raster position with body over coin over background
	function automatic logic [7:0] expected_color(input int h, input int v);
		int cx;
		int cy;
		if ((h >= `SNAKE_H_VISIBLE) || (v >= `SNAKE_V_VISIBLE))
			return 8'h00;
		if ((h < `SNAKE_FIELD_X0) || (v < `SNAKE_FIELD_Y0))
			return 8'h00;
		cx = (h - `SNAKE_FIELD_X0) / `SNAKE_CELL_PX;
		cy = (v - `SNAKE_FIELD_Y0) / `SNAKE_CELL_PX;
		if ((cx >= `SNAKE_FIELD_W) || (cy >= `SNAKE_FIELD_H))
			return 8'h00;
		for (int i = 0; i < m_len; i++)
			if ((m_x[i] == cx) && (m_y[i] == cy))
				return `SNAKE_COLOR_BODY;
		if ((cx == m_cx) && (cy == m_cy))
			return `SNAKE_COLOR_COIN;
		return `SNAKE_COLOR_BG;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks sampled on the falling edge
	////////////////////////////////////////////////////////////

	// Cycles since reset release
	always @(posedge mclk)
	begin
		if (reset)
			run_cyc <= 0;
		else
			run_cyc <= run_cyc + 1;
	end

	// Game over holds once set until reset
	assert property (@(posedge mclk) disable iff (reset) game_over |=> game_over)
		else report_mismatch("game_over", 0, 1);

	always @(negedge mclk)
	begin : check_cycle
		int n;
		int h;
		int v;
		logic exp_hs;
		logic exp_vs;
		logic [7:0] exp_col;
		if (run_cyc > RUN_LIMIT)
			abort_run("Run went past its cycle limit without finishing");
		if (run_cyc == 0)
		begin
			init_model();
			last_hfall = -1;
			last_vfall = -1;
		end
		else
		begin
			// Game updates land one edge after each tick strobe
			while (m_ticks < (run_cyc - 1) / TICK)
				step_model();
			m_dir = steer(m_dir, btn);
			// Sync spacing counted in mclk
			if (prev_hs && !hsync)
			begin
				if (last_hfall >= 0)
					assert (run_cyc - last_hfall == LINE_CYC)
						else report_mismatch("hsync period", run_cyc - last_hfall, LINE_CYC);
				last_hfall = run_cyc;
			end
			if (!prev_hs && hsync)
				assert (run_cyc - last_hfall == 2 * `SNAKE_HSYNC_LEN)
					else report_mismatch("hsync width", run_cyc - last_hfall, 2 * `SNAKE_HSYNC_LEN);
			if (prev_vs && !vsync)
			begin
				if (last_vfall >= 0)
				begin
					assert (run_cyc - last_vfall == FRAME_CYC)
						else report_mismatch("vsync period", run_cyc - last_vfall, FRAME_CYC);
					vs_periods = vs_periods + 1;
				end
				last_vfall = run_cyc;
			end
		end
		prev_hs = hsync;
		prev_vs = vsync;

		// Outputs trail the raster counters by two cycles
		if (run_cyc < 2)
		begin
			exp_hs = 1'b1;
			exp_vs = 1'b1;
			exp_col = 8'h00;
		end
		else
		begin
			n = (run_cyc - 2) / 2;
			h = n % `SNAKE_H_TOTAL;
			v = (n / `SNAKE_H_TOTAL) % `SNAKE_V_TOTAL;
			exp_hs = !((h >= `SNAKE_HSYNC_START) && (h < `SNAKE_HSYNC_START + `SNAKE_HSYNC_LEN));
			exp_vs = !((v >= `SNAKE_VSYNC_START) && (v < `SNAKE_VSYNC_START + `SNAKE_VSYNC_LEN));
			// Field rows start long after game over and the state no longer moves
			exp_col = expected_color(h, v);
		end
		if (exp_col == `SNAKE_COLOR_BODY)
			body_px = body_px + 1;
		if (exp_col == `SNAKE_COLOR_COIN)
			coin_px = coin_px + 1;
		if (exp_col == `SNAKE_COLOR_BG)
			bg_px = bg_px + 1;

		assert (hsync === exp_hs) else report_mismatch("hsync", hsync, exp_hs);
		assert (vsync === exp_vs) else report_mismatch("vsync", vsync, exp_vs);
		assert ({red, green, blue} === exp_col)
			else report_mismatch("rgb", {red, green, blue}, exp_col);
		assert (game_over === m_over) else report_mismatch("game_over", game_over, m_over);
		assert (score == m_score) else report_mismatch("score", score, m_score);
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	// One game from reset with an optional button press
	task automatic play(input logic [3:0] press, input int over_tick, input int end_cyc);
		int hold;
		@(negedge mclk);
		run_rst <= 1'b1;
		repeat (10) @(negedge mclk);
		run_rst <= 1'b0;
		repeat (4) @(negedge mclk);
		// Random hold of 1 to 16 cycles ends well before the first tick
		hold = take_bits(4) + 1;
		btn <= press;
		repeat (hold) @(negedge mclk);
		btn <= 4'b0000;
		while (!game_over)
			@(negedge mclk);
		assert ((run_cyc - 1) / TICK == over_tick)
			else report_mismatch("game_over tick", (run_cyc - 1) / TICK, over_tick);
		while (run_cyc < end_cyc)
			@(negedge mclk);
	endtask

	initial
	begin
		// Straight right through the first coin into the right wall
		play(4'b0000, 16, 2 * FRAME_CYC);
		// Up into the top wall with most of one frame drawn
		play(4'b0100, 17, FRAME_CYC * 3 / 4);
		// Left while moving right is ignored
		play(4'b0010, 16, 40 * TICK);
		if ((vs_periods > 0) && (body_px > 0) && (coin_px > 0) && (bg_px > 0))
		begin
			$display("Regression passed");
			$finish;
		end
		else
			abort_run("Some display checks were never reached");
	end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/snake_pkg.sv
rtl/game_tick.sv
rtl/direction_ctrl.sv
rtl/vga_timing.sv
rtl/snake_game.sv
rtl/snake_top.sv
testbench/clk_gen.sv
testbench/tb_snake_top.sv

// ==== Bender.yml ====
package:
  name: snake_game

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/snake_pkg.sv
      - rtl/game_tick.sv
      - rtl/direction_ctrl.sv
      - rtl/vga_timing.sv
      - rtl/snake_game.sv
      - rtl/snake_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/clk_gen.sv
      - testbench/tb_snake_top.sv
